// File: build.f
common/ql_io_pkg.sv
common/beep_if.sv
ipc/key_encoder.sv
ipc/beep_gen.sv
ipc/ipc_protocol.sv
hdl/io_regs.sv
hdl/rtc_seconds.sv
hdl/ql_io_top.sv
testbench/ql_io_properties.sv
testbench/tb_ql_io.sv

// File: testbench/tb_ql_io.sv
`timescale 1ns/1ps

module tb_ql_io;

  localparam int TICKS         = 50;
  localparam int BEEP_UNIT     = 4;
  localparam int RESET_TIMEOUT = 20;

  logic                   clk_cpu = 1'b0;
  logic                   reset;
  logic                   i_bus_valid;
  logic                   i_bus_rw;
  ql_io_pkg::io_offset_t  i_bus_addr;
  logic                   i_bus_uds_n;
  logic                   i_bus_lds_n;
  ql_io_pkg::word_t       i_bus_wdata;
  logic                   i_vsync;
  ql_io_pkg::kbd_matrix_t i_kbd_matrix;
  logic                   i_key_event;
  ql_io_pkg::word_t       o_bus_rdata;
  logic                   o_ipl1_n;
  logic                   o_beep;

  logic [31:0] lfsr_state;
  int          error_count;
  int          tests_run;
  int          tests_failed;

  ql_io_top #(.TICKS_PER_SECOND(TICKS), .BEEP_UNIT_CYCLES(BEEP_UNIT)) i_dut (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_bus_valid  (i_bus_valid),
    .i_bus_rw     (i_bus_rw),
    .i_bus_addr   (i_bus_addr),
    .i_bus_uds_n  (i_bus_uds_n),
    .i_bus_lds_n  (i_bus_lds_n),
    .i_bus_wdata  (i_bus_wdata),
    .i_vsync      (i_vsync),
    .i_kbd_matrix (i_kbd_matrix),
    .i_key_event  (i_key_event),
    .o_bus_rdata  (o_bus_rdata),
    .o_ipl1_n     (o_ipl1_n),
    .o_beep       (o_beep)
  );

  always #2 clk_cpu = ~clk_cpu;

  // ==============================
  // Random source and models
  // ==============================
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_random(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_state[0]};  // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic ql_io_pkg::word_t key_code(ql_io_pkg::kbd_matrix_t m);
    ql_io_pkg::key_pos_t row;
    ql_io_pkg::key_pos_t col;
    ql_io_pkg::byte_t    bits;
    logic                found;
    row = 3'd7;
    col = 3'd7;
    found = 1'b0;
    for (int r = 0; r < 8; r++) begin
      if (!found && m[r*8 +: 8] != 8'h00) begin
        row = 3'(r);
        found = 1'b1;
      end
    end
    bits = m[int'(row)*8 +: 8];
    // Modifier plus a real key in row 7 hides the modifier columns
    if (row == 3'd7 && (m[56] || m[57] || m[58]) && m[63:59] != 5'd0) bits[2:0] = 3'b000;
    found = 1'b0;
    for (int c = 0; c < 8; c++) begin
      if (!found && bits[c]) begin
        col = 3'(c);
        found = 1'b1;
      end
    end
    return {4'b0001, 1'b0, m[56], m[57], m[58], 2'b00, ~row, col};
  endfunction

  function automatic logic [63:0] sound_params(ql_io_pkg::byte_t pitch_byte,
                                               ql_io_pkg::duration_t dur);
    logic [63:0] p;
    p = '0;
    p[63:56] = pitch_byte;  // Byte 0
    p[31:24] = dur[7:0];    // Byte 4
    p[22:16] = dur[14:8];   // Byte 5 bits 6:0
    return p;
  endfunction

  // ==============================
  // Checks and reporting
  // ==============================
  task automatic check_word(string what, ql_io_pkg::word_t got, ql_io_pkg::word_t exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(string what, ql_io_pkg::byte_t got, ql_io_pkg::byte_t exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(string name, int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("%-10s ok", name);
    end else begin
      tests_failed++;
      $display("%-10s %0d check(s) failed", name, error_count - errs_before);
    end
  endtask

  // ==============================
  // Bus and IPC tasks
  // ==============================
  task automatic wait_reset_released();
    int n;
    n = 0;
    while (reset && n < RESET_TIMEOUT) begin
      @(negedge clk_cpu);
      n++;
    end
    if (reset) begin
      error_count++;
      $display("Timeout: reset still asserted when a bus access was due");
    end
  endtask

  task automatic bus_write(ql_io_pkg::io_offset_t addr, logic uds_n, logic lds_n,
                           ql_io_pkg::word_t data);
    wait_reset_released();
    i_bus_valid = 1'b1;
    i_bus_rw    = 1'b0;
    i_bus_addr  = addr;
    i_bus_uds_n = uds_n;
    i_bus_lds_n = lds_n;
    i_bus_wdata = data;
    @(negedge clk_cpu);
    i_bus_valid = 1'b0;
    i_bus_uds_n = 1'b1;
    i_bus_lds_n = 1'b1;
    @(negedge clk_cpu);  // Write has landed
  endtask

  task automatic bus_read(ql_io_pkg::io_offset_t addr, output ql_io_pkg::word_t data);
    wait_reset_released();
    i_bus_valid = 1'b1;
    i_bus_rw    = 1'b1;
    i_bus_addr  = addr;
    @(negedge clk_cpu);
    i_bus_valid = 1'b0;
    data = o_bus_rdata;
  endtask

  task automatic read_seconds(output ql_io_pkg::seconds_t val);
    ql_io_pkg::word_t hi;
    ql_io_pkg::word_t lo;
    ql_io_pkg::word_t hi2;
    bus_read(ql_io_pkg::OFS_TIMER, hi);
    bus_read(ql_io_pkg::OFS_TIMER_LO, lo);
    bus_read(ql_io_pkg::OFS_TIMER, hi2);
    if (hi2 != hi) bus_read(ql_io_pkg::OFS_TIMER_LO, lo);  // Carry between halves
    val = {hi2, lo};
  endtask

  task automatic ipc_send(logic [63:0] bits, int n);
    for (int i = n - 1; i >= 0; i--) begin
      bus_write(ql_io_pkg::OFS_TIMER_LO, 1'b1, 1'b0, {14'b0, bits[i], 1'b0});
    end
  endtask

  task automatic ipc_collect(int n, output ql_io_pkg::word_t val);
    ql_io_pkg::word_t rd;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bus_write(ql_io_pkg::OFS_TIMER_LO, 1'b1, 1'b0, 16'h0000);
      bus_read(ql_io_pkg::OFS_IPC_IRQ, rd);
      val = {val[14:0], rd[15]};  // Status bit 7
    end
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_rtc();
    int                  errs;
    logic [63:0]         r;
    ql_io_pkg::word_t    rd;
    ql_io_pkg::seconds_t expected;
    ql_io_pkg::seconds_t now;
    errs = error_count;
    bus_read(ql_io_pkg::OFS_TIMER, rd);
    check_word("timer upper after reset", rd, 16'h0000);
    bus_read(ql_io_pkg::OFS_TIMER_LO, rd);
    check_word("timer lower after reset", rd, 16'h0000);
    bus_write(ql_io_pkg::OFS_TIMER, 1'b0, 1'b1, 16'h0000);  // Restart prescaler
    for (int i = 0; i < 4; i++) begin
      take_random(8, r);
      expected[i*8 +: 8] = r[7:0];
      bus_write(ql_io_pkg::OFS_TIMER, 1'b1, 1'b0, {8'h00, r[7:0]});
    end
    read_seconds(now);
    check_word("adjusted upper", now[31:16], expected[31:16]);
    check_word("adjusted lower", now[15:0], expected[15:0]);
    repeat (3 * TICKS) @(negedge clk_cpu);
    read_seconds(now);
    if (now - expected < 2 || now - expected > 4) begin
      error_count++;
      $display("[FAIL] t=%0t seconds grew by %0d, expected 2 to 4", $time, now - expected);
    end
    bus_write(ql_io_pkg::OFS_TIMER, 1'b0, 1'b1, 16'h0000);
    read_seconds(now);
    check_word("upper after reset write", now[31:16], 16'h0000);
    check_word("lower after reset write", now[15:0], 16'h0000);
    report_test("rtc", errs);
  endtask

  task automatic test_vsync_irq();
    int               errs;
    int               n;
    ql_io_pkg::word_t rd;
    errs = error_count;
    bus_write(ql_io_pkg::OFS_TIMER, 1'b0, 1'b1, 16'h0000);  // Seconds bit 0 low
    i_vsync = 1'b0;
    n = 0;
    while (o_ipl1_n && n < 4) begin
      @(negedge clk_cpu);
      n++;
    end
    if (o_ipl1_n) begin
      error_count++;
      $display("Timeout: o_ipl1_n did not go low within 4 cycles of vsync");
    end
    i_vsync = 1'b1;
    bus_read(ql_io_pkg::OFS_IPC_IRQ, rd);
    check_word("pending after vsync", rd, 16'h0008);
    bus_write(ql_io_pkg::OFS_IPC_IRQ, 1'b1, 1'b0, 16'h0008);
    check_bit("ipl1_n after ack", o_ipl1_n, 1'b1);
    bus_read(ql_io_pkg::OFS_IPC_IRQ, rd);
    check_word("pending after ack", rd, 16'h0000);
    bus_write(ql_io_pkg::OFS_TIMER, 1'b1, 1'b0, 16'h0001);  // Seconds to one
    bus_read(ql_io_pkg::OFS_IPC_IRQ, rd);
    check_word("pending timer bit", rd, 16'h0020);
    report_test("vsync", errs);
  endtask

  task automatic test_status_cmd();
    int               errs;
    ql_io_pkg::word_t rd;
    errs = error_count;
    i_key_event = 1'b1;
    @(negedge clk_cpu);
    i_key_event = 1'b0;
    bus_write(ql_io_pkg::OFS_TIMER_LO, 1'b1, 1'b0, 16'h0003);  // Sync write
    ipc_send(64'(ql_io_pkg::cmd_status), 4);
    ipc_collect(ql_io_pkg::RETURN_BITS_STATUS, rd);
    check_byte("status with key", rd[7:0], 8'h01);
    ipc_send(64'(ql_io_pkg::cmd_status), 4);
    ipc_collect(ql_io_pkg::RETURN_BITS_STATUS, rd);
    check_byte("status repeated", rd[7:0], 8'h00);
    report_test("status", errs);
  endtask

  task automatic test_read_key();
    int                     errs;
    logic [63:0]            r;
    int                     row;
    ql_io_pkg::kbd_matrix_t m;
    ql_io_pkg::word_t       rd;
    errs = error_count;
    for (int t = 0; t < 5; t++) begin
      m = '0;
      take_random(3, r);
      row = int'(r[2:0]);
      take_random(3, r);
      if (t < 4) m[row*8 + int'(r[2:0])] = 1'b1;
      else begin
        m[56] = 1'b1;               // Shift with a key in row 7
        m[59 + int'(r[1:0])] = 1'b1;
      end
      i_kbd_matrix = m;
      ipc_send(64'(ql_io_pkg::cmd_read_key), 4);
      ipc_collect(ql_io_pkg::RETURN_BITS_KEY, rd);
      check_word($sformatf("key code for %h", m), rd, key_code(m));
    end
    report_test("read_key", errs);
  endtask

  task automatic test_key_row();
    int                     errs;
    logic [63:0]            r;
    logic [63:0]            sel;
    ql_io_pkg::word_t       rd;
    errs = error_count;
    for (int t = 0; t < 2; t++) begin
      take_random(64, r);
      take_random(4, sel);
      i_kbd_matrix = r;
      ipc_send(64'(ql_io_pkg::cmd_key_row), 4);
      ipc_send(sel, 4);
      ipc_collect(ql_io_pkg::RETURN_BITS_ROW, rd);
      check_byte($sformatf("key row %0d", sel[2:0]), rd[7:0], r[int'(sel[2:0])*8 +: 8]);
    end
    report_test("key_row", errs);
  endtask

  task automatic test_beep();
    int   errs;
    int   n;
    int   toggles;
    logic saw_high;
    logic last;
    errs = error_count;
    ipc_send(64'(ql_io_pkg::cmd_set_sound), 4);
    ipc_send(sound_params(8'd254, 15'd5), ql_io_pkg::PARAM_BITS_SOUND);
    saw_high = 1'b0;
    for (int cyc = 0; cyc < 60; cyc++) begin
      if (cyc < 40 && o_beep) saw_high = 1'b1;
      if (cyc >= 40) check_bit("beep after duration", o_beep, 1'b0);
      @(negedge clk_cpu);
    end
    if (!saw_high) begin
      error_count++;
      $display("Beeper never went high during a 5 unit tone");
    end
    ipc_send(64'(ql_io_pkg::cmd_set_sound), 4);
    ipc_send(sound_params(8'd254, 15'd0), ql_io_pkg::PARAM_BITS_SOUND);
    toggles = 0;
    n = 0;
    last = o_beep;
    while (toggles < 4 && n < 100) begin
      @(negedge clk_cpu);
      n++;
      if (o_beep !== last) toggles++;
      last = o_beep;
    end
    if (toggles < 4) begin
      error_count++;
      $display("Timeout: continuous tone toggled only %0d times", toggles);
    end
    ipc_send(64'(ql_io_pkg::cmd_kill_sound), 4);
    repeat (2) @(negedge clk_cpu);  // Stop pulse reaches the generator
    for (int cyc = 0; cyc < 40; cyc++) begin
      check_bit("beep after kill", o_beep, 1'b0);
      @(negedge clk_cpu);
    end
    report_test("beep", errs);
  endtask

  initial begin
    reset        = 1'b1;
    i_bus_valid  = 1'b0;
    i_bus_rw     = 1'b1;
    i_bus_addr   = '0;
    i_bus_uds_n  = 1'b1;
    i_bus_lds_n  = 1'b1;
    i_bus_wdata  = '0;
    i_vsync      = 1'b1;
    i_kbd_matrix = '0;
    i_key_event  = 1'b0;
    lfsr_state   = 32'h1c7091e2;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(negedge clk_cpu);
    reset = 1'b0;

    test_rtc();
    test_vsync_irq();
    test_status_cmd();
    test_read_key();
    test_key_row();
    test_beep();

    $display("Summary: %0d tests, %0d failed, %0d failed checks",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: testbench/ql_io_properties.sv
`timescale 1ns/1ps

module ql_io_properties (
  input logic             clk_cpu,
  input logic             reset,
  input logic             i_bus_valid,
  input logic             i_bus_rw,
  input ql_io_pkg::word_t o_bus_rdata,
  input logic             o_ipl1_n,
  input logic             o_beep
);

  // Interrupt request idle through reset and one cycle beyond
  a_ipl_idle_reset: assert property (@(posedge clk_cpu) reset |=> o_ipl1_n)
    else $error("o_ipl1_n active during or right after reset");

  a_beep_idle_reset: assert property (@(posedge clk_cpu) reset |=> !o_beep)
    else $error("o_beep high during or right after reset");

  // Read data moves only on the edge after a read pulse
  a_rdata_on_read: assert property (@(posedge clk_cpu) disable iff (reset)
    !$stable(o_bus_rdata) |-> $past(i_bus_valid && i_bus_rw))
    else $error("o_bus_rdata changed without a read");

endmodule

bind ql_io_top ql_io_properties u_props (
  .clk_cpu     (clk_cpu),
  .reset       (reset),
  .i_bus_valid (i_bus_valid),
  .i_bus_rw    (i_bus_rw),
  .o_bus_rdata (o_bus_rdata),
  .o_ipl1_n    (o_ipl1_n),
  .o_beep      (o_beep)
);

// File: hdl/ql_io_top.sv
`timescale 1ns/1ps

module ql_io_top #(
  parameter int TICKS_PER_SECOND = 27000000,
  parameter int BEEP_UNIT_CYCLES = 1944
) (
  input  logic                   clk_cpu,
  input  logic                   reset,
  // QL bus
  input  logic                   i_bus_valid,
  input  logic                   i_bus_rw,      // 1 = read
  input  ql_io_pkg::io_offset_t  i_bus_addr,
  input  logic                   i_bus_uds_n,
  input  logic                   i_bus_lds_n,
  input  ql_io_pkg::word_t       i_bus_wdata,
  // Peripherals
  input  logic                   i_vsync,
  input  ql_io_pkg::kbd_matrix_t i_kbd_matrix,
  input  logic                   i_key_event,
  output ql_io_pkg::word_t       o_bus_rdata,
  output logic                   o_ipl1_n,
  output logic                   o_beep
);

  logic                  wr_stb;
  ql_io_pkg::io_target_e wr_target;
  ql_io_pkg::word_t      wr_data;
  ql_io_pkg::seconds_t   seconds;
  logic                  ret_bit;

  beep_if beep_bus ();

  io_regs u_io_regs (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .i_bus_valid (i_bus_valid),
    .i_bus_rw    (i_bus_rw),
    .i_bus_addr  (i_bus_addr),
    .i_bus_uds_n (i_bus_uds_n),
    .i_bus_lds_n (i_bus_lds_n),
    .i_bus_wdata (i_bus_wdata),
    .i_vsync     (i_vsync),
    .i_seconds   (seconds),
    .i_ret_bit   (ret_bit),
    .o_wr_stb    (wr_stb),
    .o_target    (wr_target),
    .o_wdata     (wr_data),
    .o_bus_rdata (o_bus_rdata),
    .o_ipl1_n    (o_ipl1_n)
  );

  rtc_seconds #(.TICKS_PER_SECOND(TICKS_PER_SECOND)) u_rtc (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .i_wr_stb  (wr_stb),
    .i_target  (wr_target),
    .i_wdata   (wr_data),
    .o_seconds (seconds)
  );

  ipc_protocol u_ipc (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_wr_stb     (wr_stb),
    .i_target     (wr_target),
    .i_wdata      (wr_data),
    .i_kbd_matrix (i_kbd_matrix),
    .i_key_event  (i_key_event),
    .o_ret_bit    (ret_bit),
    .beep         (beep_bus.ctrl)
  );

  beep_gen #(.BEEP_UNIT_CYCLES(BEEP_UNIT_CYCLES)) u_beep (
    .clk_cpu (clk_cpu),
    .reset   (reset),
    .beep    (beep_bus.tone),
    .o_beep  (o_beep)
  );

endmodule

// File: hdl/rtc_seconds.sv
`timescale 1ns/1ps

module rtc_seconds #(
  parameter int TICKS_PER_SECOND = 27000000
) (
  input  logic                  clk_cpu,
  input  logic                  reset,
  input  logic                  i_wr_stb,
  input  ql_io_pkg::io_target_e i_target,
  input  ql_io_pkg::word_t      i_wdata,
  output ql_io_pkg::seconds_t   o_seconds
);

  logic [$clog2(TICKS_PER_SECOND+1)-1:0] prescaler;
  logic [1:0]                            byte_idx;   // Next byte for adjust
  logic                                  sec_tick;
  logic                                  rst_wr;
  logic                                  adj_wr;

  assign sec_tick = (prescaler == TICKS_PER_SECOND - 1);
  assign rst_wr   = i_wr_stb && (i_target == ql_io_pkg::tgt_timer_reset);
  assign adj_wr   = i_wr_stb && (i_target == ql_io_pkg::tgt_timer_adjust);

  always_ff @(posedge clk_cpu) begin
    if (reset || rst_wr) begin
      prescaler <= '0;
      o_seconds <= '0;
      byte_idx  <= '0;
    end else begin
      prescaler <= sec_tick ? '0 : prescaler + 1'b1;
      if (sec_tick) o_seconds <= o_seconds + 32'd1;
      // Adjust overrides the tick for its own byte
      if (adj_wr) begin
        o_seconds[{byte_idx, 3'b000} +: 8] <= i_wdata[7:0];
        byte_idx <= byte_idx + 2'd1;
      end
    end
  end

endmodule

// File: hdl/io_regs.sv
`timescale 1ns/1ps

module io_regs (
  input  logic                  clk_cpu,
  input  logic                  reset,
  input  logic                  i_bus_valid,
  input  logic                  i_bus_rw,
  input  ql_io_pkg::io_offset_t i_bus_addr,
  input  logic                  i_bus_uds_n,
  input  logic                  i_bus_lds_n,
  input  ql_io_pkg::word_t      i_bus_wdata,
  input  logic                  i_vsync,
  input  ql_io_pkg::seconds_t   i_seconds,
  input  logic                  i_ret_bit,
  output logic                  o_wr_stb,
  output ql_io_pkg::io_target_e o_target,
  output ql_io_pkg::word_t      o_wdata,
  output ql_io_pkg::word_t      o_bus_rdata,
  output logic                  o_ipl1_n
);

  ql_io_pkg::io_target_e wr_target;
  ql_io_pkg::word_t      read_word;
  ql_io_pkg::byte_t      pending;
  ql_io_pkg::byte_t      status;
  logic                  vsync_q;
  logic                  vsync_q2;
  logic                  vsync_flag;
  logic                  irq_ack;

  // ==============================
  // Write decode
  // ==============================
  always_comb begin
    wr_target = ql_io_pkg::tgt_none;
    case (i_bus_addr)
      ql_io_pkg::OFS_TIMER: begin
        if (!i_bus_uds_n) wr_target = ql_io_pkg::tgt_timer_reset;  // Upper byte wins
        else if (!i_bus_lds_n) wr_target = ql_io_pkg::tgt_timer_adjust;
      end
      ql_io_pkg::OFS_TIMER_LO: if (!i_bus_lds_n) wr_target = ql_io_pkg::tgt_ipc_bit;
      ql_io_pkg::OFS_IPC_IRQ:  if (!i_bus_lds_n) wr_target = ql_io_pkg::tgt_irq_ack;
      default: ;
    endcase
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      o_wr_stb <= 1'b0;
      o_target <= ql_io_pkg::tgt_none;
    end else begin
      o_wr_stb <= i_bus_valid && !i_bus_rw && (wr_target != ql_io_pkg::tgt_none);
      o_target <= wr_target;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (i_bus_valid && !i_bus_rw) o_wdata <= i_bus_wdata;
  end

  // ==============================
  // Read mux
  // ==============================
  always_comb begin
    pending = '0;
    pending[ql_io_pkg::IRQ_VSYNC_BIT] = vsync_flag;
    pending[ql_io_pkg::IRQ_TIMER_BIT] = i_seconds[0];
    status = '0;
    status[ql_io_pkg::IPC_RET_BIT] = i_ret_bit;
    case (i_bus_addr)
      ql_io_pkg::OFS_TIMER:    read_word = i_seconds[31:16];
      ql_io_pkg::OFS_TIMER_LO: read_word = i_seconds[15:0];
      ql_io_pkg::OFS_IPC_IRQ:  read_word = {status, pending};
      default:                 read_word = '0;
    endcase
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) o_bus_rdata <= '0;
    else if (i_bus_valid && i_bus_rw) o_bus_rdata <= read_word;  // Held until next read
  end

  // Vsync falling edge sets the flag and an acknowledge clears it
  assign irq_ack = o_wr_stb && (o_target == ql_io_pkg::tgt_irq_ack) &&
                   o_wdata[ql_io_pkg::IRQ_VSYNC_BIT];

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q    <= 1'b1;
      vsync_q2   <= 1'b1;
      vsync_flag <= 1'b0;
    end else begin
      vsync_q  <= i_vsync;
      vsync_q2 <= vsync_q;
      if (irq_ack) vsync_flag <= 1'b0;
      else if (!vsync_q && vsync_q2) vsync_flag <= 1'b1;
    end
  end

  assign o_ipl1_n = !vsync_flag;  // Level 1 request

endmodule

// File: ipc/ipc_protocol.sv
`timescale 1ns/1ps

module ipc_protocol (
  input  logic                   clk_cpu,
  input  logic                   reset,
  input  logic                   i_wr_stb,
  input  ql_io_pkg::io_target_e  i_target,
  input  ql_io_pkg::word_t       i_wdata,
  input  ql_io_pkg::kbd_matrix_t i_kbd_matrix,
  input  logic                   i_key_event,
  output logic                   o_ret_bit,
  beep_if.ctrl                   beep
);

  ql_io_pkg::ipc_state_e state;
  ql_io_pkg::ipc_cmd_e   cmd_q;
  logic [6:0]            bit_cnt;      // Counted writes in this phase
  logic [3:0]            nibble_q;
  logic [15:0]           ret_sr;       // MSB is the status bit
  logic [63:0]           param_sr;
  logic                  key_pressed;
  logic                  ipc_wr;
  logic                  counted;
  logic [3:0]            nibble_next;
  logic [63:0]           param_next;
  logic [6:0]            ret_last;
  ql_io_pkg::key_pos_t   key_row;
  ql_io_pkg::key_pos_t   key_col;
  logic                  key_shift;
  logic                  key_ctrl;
  logic                  key_alt;

  key_encoder u_key_encoder (
    .i_kbd_matrix (i_kbd_matrix),
    .o_row        (key_row),
    .o_col        (key_col),
    .o_shift      (key_shift),
    .o_ctrl       (key_ctrl),
    .o_alt        (key_alt)
  );

  assign ipc_wr      = i_wr_stb && (i_target == ql_io_pkg::tgt_ipc_bit);
  assign counted     = ipc_wr && !i_wdata[0];      // Bit 0 set is a sync write
  assign nibble_next = {nibble_q[2:0], i_wdata[1]};
  assign param_next  = {param_sr[62:0], i_wdata[1]};
  assign o_ret_bit   = ret_sr[15];

  // Length of the reply for the current command
  always_comb begin
    case (cmd_q)
      ql_io_pkg::cmd_read_key: ret_last = 7'(ql_io_pkg::RETURN_BITS_KEY - 1);
      ql_io_pkg::cmd_key_row:  ret_last = 7'(ql_io_pkg::RETURN_BITS_ROW - 1);
      default:                 ret_last = 7'(ql_io_pkg::RETURN_BITS_STATUS - 1);
    endcase
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state       <= ql_io_pkg::ipc_cmd;
      cmd_q       <= ql_io_pkg::ipc_cmd_e'(4'd0);
      bit_cnt     <= '0;
      nibble_q    <= '0;
      ret_sr      <= '0;
      key_pressed <= 1'b0;
      beep.start  <= 1'b0;
      beep.stop   <= 1'b0;
    end else begin
      beep.start <= 1'b0;
      beep.stop  <= 1'b0;
      if (i_key_event) key_pressed <= 1'b1;
      if (ipc_wr) nibble_q <= nibble_next;
      if (counted) begin
        bit_cnt <= bit_cnt + 7'd1;
        case (state)
          ql_io_pkg::ipc_cmd: begin
            if (bit_cnt == 7'd3) begin  // Fourth bit completes the nibble
              bit_cnt <= '0;
              cmd_q   <= ql_io_pkg::ipc_cmd_e'(nibble_next);
              case (nibble_next)
                ql_io_pkg::cmd_status: begin
                  state       <= ql_io_pkg::ipc_send;
                  ret_sr      <= {7'b0, key_pressed, 8'b0};
                  key_pressed <= 1'b0;
                end
                ql_io_pkg::cmd_read_key: begin
                  state  <= ql_io_pkg::ipc_send;
                  ret_sr <= {4'b0001, 1'b0, key_shift, key_ctrl, key_alt, 2'b00,
                             ~key_row, key_col};
                end
                ql_io_pkg::cmd_key_row:    state <= ql_io_pkg::ipc_param;
                ql_io_pkg::cmd_set_sound:  state <= ql_io_pkg::ipc_sound;
                ql_io_pkg::cmd_kill_sound: beep.stop <= 1'b1;
                default: ;  // Other codes ignored
              endcase
            end
          end
          ql_io_pkg::ipc_send: begin
            if (bit_cnt != 7'd0) ret_sr <= {ret_sr[14:0], 1'b0};
            if (bit_cnt == ret_last) begin
              state   <= ql_io_pkg::ipc_cmd;
              bit_cnt <= '0;
            end
          end
          ql_io_pkg::ipc_param: begin
            if (bit_cnt == 7'(ql_io_pkg::PARAM_BITS_ROW - 1)) begin
              state   <= ql_io_pkg::ipc_send;
              bit_cnt <= '0;
              ret_sr  <= {i_kbd_matrix[{nibble_next[2:0], 3'b000} +: 8], 8'b0};
            end
          end
          ql_io_pkg::ipc_sound: begin
            param_sr <= param_next;
            if (bit_cnt == 7'(ql_io_pkg::PARAM_BITS_SOUND - 1)) begin
              state         <= ql_io_pkg::ipc_cmd;
              bit_cnt       <= '0;
              beep.start    <= 1'b1;
              // Byte 0 sits at the top and byte n at 63-8n
              beep.pitch    <= ql_io_pkg::PITCH_BASE - {1'b0, param_next[63:56]};
              beep.duration <= {param_next[22:16], param_next[31:24]};
            end
          end
          default: state <= ql_io_pkg::ipc_cmd;
        endcase
      end
    end
  end

endmodule

// File: ipc/beep_gen.sv
`timescale 1ns/1ps

module beep_gen #(
  parameter int BEEP_UNIT_CYCLES = 1944
) (
  input  logic clk_cpu,
  input  logic reset,
  beep_if.tone beep,
  output logic o_beep
);

  logic [$clog2(BEEP_UNIT_CYCLES+1)-1:0] unit_cnt;
  logic                                  unit_tick;
  logic                                  active;
  logic                                  continuous;   // Zero duration
  ql_io_pkg::pitch_t                     pitch_q;
  ql_io_pkg::pitch_t                     half_cnt;
  ql_io_pkg::duration_t                  dur_cnt;
  logic                                  beep_q;

  assign unit_tick = active && (unit_cnt == BEEP_UNIT_CYCLES - 1);
  assign o_beep    = beep_q;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      active     <= 1'b0;
      continuous <= 1'b0;
      unit_cnt   <= '0;
      half_cnt   <= '0;
      dur_cnt    <= '0;
      beep_q     <= 1'b0;
    end else if (beep.start) begin
      active     <= 1'b1;
      continuous <= (beep.duration == '0);
      unit_cnt   <= '0;
      half_cnt   <= '0;
      dur_cnt    <= beep.duration;
      pitch_q    <= beep.pitch;
      beep_q     <= 1'b0;
    end else if (beep.stop) begin
      active <= 1'b0;
      beep_q <= 1'b0;
    end else if (active) begin
      unit_cnt <= unit_tick ? '0 : unit_cnt + 1'b1;
      if (unit_tick) begin
        if (half_cnt == pitch_q - 9'd1) begin  // Half period done
          half_cnt <= '0;
          beep_q   <= !beep_q;
        end else begin
          half_cnt <= half_cnt + 9'd1;
        end
        if (!continuous) begin
          if (dur_cnt == '0) begin
            active <= 1'b0;
            beep_q <= 1'b0;
          end else begin
            dur_cnt <= dur_cnt - 15'd1;
          end
        end
      end
    end
  end

endmodule

// File: ipc/key_encoder.sv
`timescale 1ns/1ps

module key_encoder (
  input  ql_io_pkg::kbd_matrix_t i_kbd_matrix,
  output ql_io_pkg::key_pos_t    o_row,
  output ql_io_pkg::key_pos_t    o_col,
  output logic                   o_shift,
  output logic                   o_ctrl,
  output logic                   o_alt
);

  logic [7:0] row_bits;
  logic       row7_mask;

  assign o_shift = i_kbd_matrix[56];
  assign o_ctrl  = i_kbd_matrix[57];
  assign o_alt   = i_kbd_matrix[58];

  // Modifier held together with a real key in row 7
  assign row7_mask = (|i_kbd_matrix[58:56]) && (|i_kbd_matrix[63:59]);

  always_comb begin
    o_row = 3'd7;  // Also the no-key value
    for (int r = 6; r >= 0; r--) begin
      if (|i_kbd_matrix[r*8 +: 8]) o_row = 3'(r);
    end

    row_bits = i_kbd_matrix[{o_row, 3'b000} +: 8];
    if (o_row == 3'd7 && row7_mask) row_bits[2:0] = 3'b000;

    o_col = 3'd7;
    for (int c = 6; c >= 0; c--) begin
      if (row_bits[c]) o_col = 3'(c);  // Lowest set column wins
    end
  end

endmodule

// File: common/beep_if.sv
`timescale 1ns/1ps

// Tone command from the IPC to the beeper
interface beep_if;

  logic                  start;     // One-cycle pulse
  logic                  stop;      // One-cycle pulse
  ql_io_pkg::pitch_t     pitch;
  ql_io_pkg::duration_t  duration;  // Zero means until stopped

  modport ctrl (
    output start,
    output stop,
    output pitch,
    output duration
  );

  modport tone (
    input start,
    input stop,
    input pitch,
    input duration
  );

endinterface

// File: common/ql_io_pkg.sv
package ql_io_pkg;

  // ==============================
  // Widths
  // ==============================
  typedef logic [15:0] word_t;        // Bus data word
  typedef logic [7:0]  byte_t;
  typedef logic [5:0]  io_offset_t;   // Address bits 6:1
  typedef logic [31:0] seconds_t;
  typedef logic [63:0] kbd_matrix_t;  // Byte n is row n
  typedef logic [2:0]  key_pos_t;
  typedef logic [8:0]  pitch_t;       // Half-period of 1 to 256 units
  typedef logic [14:0] duration_t;

  // ==============================
  // Enums
  // ==============================
  typedef enum logic [2:0] {
    tgt_none,
    tgt_timer_reset,
    tgt_timer_adjust,
    tgt_ipc_bit,
    tgt_irq_ack
  } io_target_e;

  typedef enum logic [1:0] {
    ipc_cmd,    // Collecting a command nibble
    ipc_send,   // Shifting out return bits
    ipc_param,  // Key row parameter
    ipc_sound   // Sound parameters
  } ipc_state_e;

  typedef enum logic [3:0] {
    cmd_status     = 4'd1,
    cmd_read_key   = 4'd8,
    cmd_key_row    = 4'd9,
    cmd_set_sound  = 4'd10,
    cmd_kill_sound = 4'd11
  } ipc_cmd_e;

  // I/O page word offsets
  localparam io_offset_t OFS_TIMER    = 6'd0;
  localparam io_offset_t OFS_TIMER_LO = 6'd1;
  localparam io_offset_t OFS_IPC_IRQ  = 6'd16;

  localparam int IRQ_VSYNC_BIT = 3;
  localparam int IRQ_TIMER_BIT = 5;
  localparam int IPC_RET_BIT   = 7;

  localparam int RETURN_BITS_STATUS = 8;
  localparam int RETURN_BITS_KEY    = 16;
  localparam int RETURN_BITS_ROW    = 8;
  localparam int PARAM_BITS_ROW     = 4;
  localparam int PARAM_BITS_SOUND   = 64;

  localparam pitch_t PITCH_BASE = 9'd256;  // Pitch byte counts down from here

endpackage
